// File: build.f
src/ctrlPkg.sv
src/decodeIf.sv
src/instrDecoder.sv
src/stepSequencer.sv
src/cpuControl.sv
verification/cpuControlTb.sv

// File: Bender.yml
package:
  name: cpu_control

sources:
  - src/ctrlPkg.sv
  - src/decodeIf.sv
  - src/instrDecoder.sv
  - src/stepSequencer.sv
  - src/cpuControl.sv
  - target: test
    files:
      - verification/cpuControlTb.sv

// File: verification/cpuControlTb.sv
module cpuControlTb;

    localparam ctrlPkg::regSelT SpLowReg = 4'd14;
    localparam int resetCycles = 10;
    localparam int numInstr    = 200;
    localparam int hltHold     = 4;   // cycles a HLT word stays on the bus
    localparam int cycleLimit  = resetCycles + 3 * numInstr + 50;

    logic               clk;
    logic               rstN;
    ctrlPkg::instrT     iMemOut;
    logic               carryFlag;
    logic               zeroFlag;
    logic               negativeFlag;
    ctrlPkg::regSrcT    regFileSrc;
    ctrlPkg::regSelT    regFileOutBSelect;
    logic               regFileWriteEnable;
    logic               regFileIncPair;
    logic               regFileDecPair;
    logic               aluSrcBSelect;
    ctrlPkg::aluModeT   aluMode;
    logic               flagEnable;
    ctrlPkg::dataSelT   dMemDataSelect;
    ctrlPkg::ioAddrSelT dMemIOAddressSelect;
    logic               dMemIOWriteEn;
    logic               dMemIOReadEn;
    ctrlPkg::pcSrcT     iMemAddrSelect;
    logic               iMemReadEnable;
    logic               pcWriteEn;

    integer seed       = 62782;
    int     errorCount = 0;
    int     checkCount = 0;
    int     cycleCount = 0;
    int     phase      = 0;   // cycle index inside the current instruction

    ctrlPkg::opClassT kind;     // class the current word was built as
    logic             taken;    // condition result from the chosen flags
    int               expLen;
    ctrlPkg::aluModeT expMode;
    logic             expFlags;
    ctrlPkg::regSelT  expRegB;

    cpuControl #(
        .SpLowReg(SpLowReg)
    ) dut (
        .clk                (clk),
        .rstN               (rstN),
        .iMemOut            (iMemOut),
        .carryFlag          (carryFlag),
        .zeroFlag           (zeroFlag),
        .negativeFlag       (negativeFlag),
        .regFileSrc         (regFileSrc),
        .regFileOutBSelect  (regFileOutBSelect),
        .regFileWriteEnable (regFileWriteEnable),
        .regFileIncPair     (regFileIncPair),
        .regFileDecPair     (regFileDecPair),
        .aluSrcBSelect      (aluSrcBSelect),
        .aluMode            (aluMode),
        .flagEnable         (flagEnable),
        .dMemDataSelect     (dMemDataSelect),
        .dMemIOAddressSelect(dMemIOAddressSelect),
        .dMemIOWriteEn      (dMemIOWriteEn),
        .dMemIOReadEn       (dMemIOReadEn),
        .iMemAddrSelect     (iMemAddrSelect),
        .iMemReadEnable     (iMemReadEnable),
        .pcWriteEn          (pcWriteEn)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("checks: %0d, errors: %0d", checkCount, errorCount);
            $display("TEST FAILED");
            $finish;
        end
    end

    // codes 0 and 7 always hold
    function automatic logic condHolds(input logic [2:0] cond, input logic c,
                                       input logic z, input logic n);
        case (cond)
            3'd1:    return c;
            3'd2:    return !c;
            3'd3:    return z;
            3'd4:    return !z;
            3'd5:    return n;
            3'd6:    return !n;
            default: return 1'b1;
        endcase
    endfunction

    task automatic compareField(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errorCount++;
            $display("error: %s expected 0x%0h got 0x%0h (word 0x%04h, cycle %0d)",
                     name, exp, got, iMemOut, phase);
        end
    endtask

    task automatic expectIdle();
        compareField("regFileWriteEnable", 16'(regFileWriteEnable), 16'(0));
        compareField("regFileIncPair", 16'(regFileIncPair), 16'(0));
        compareField("regFileDecPair", 16'(regFileDecPair), 16'(0));
        compareField("dMemIOWriteEn", 16'(dMemIOWriteEn), 16'(0));
        compareField("dMemIOReadEn", 16'(dMemIOReadEn), 16'(0));
        compareField("iMemReadEnable", 16'(iMemReadEnable), 16'(0));
        compareField("pcWriteEn", 16'(pcWriteEn), 16'(0));
    endtask

    task automatic verifyCycle();
        logic last;
        logic callPush;
        logic retPop;
        logic expWrite;
        logic expRead;
        logic expStore;
        last     = (phase == expLen - 1);
        callPush = (kind == ctrlPkg::clsCall) && taken;
        retPop   = (kind == ctrlPkg::clsRet) && taken;
        expWrite = (kind inside {ctrlPkg::clsAluImm, ctrlPkg::clsAluReg}) ||
                   ((kind inside {ctrlPkg::clsIn, ctrlPkg::clsLoad}) && phase == 1);
        expRead  = (kind inside {ctrlPkg::clsIn, ctrlPkg::clsLoad}) || retPop;
        expStore = (kind inside {ctrlPkg::clsOut, ctrlPkg::clsStore}) || callPush;
        compareField("pcWriteEn", 16'(pcWriteEn), 16'(kind != ctrlPkg::clsHlt && last));
        compareField("regFileWriteEnable", 16'(regFileWriteEnable), 16'(expWrite));
        compareField("dMemIOReadEn", 16'(dMemIOReadEn), 16'(expRead));
        compareField("dMemIOWriteEn", 16'(dMemIOWriteEn), 16'(expStore));
        compareField("regFileDecPair", 16'(regFileDecPair), 16'(callPush));
        case (kind)
            ctrlPkg::clsAluImm, ctrlPkg::clsAluReg: begin
                compareField("aluMode", 16'(aluMode), 16'(expMode));
                compareField("flagEnable", 16'(flagEnable), 16'(expFlags));
                compareField("aluSrcBSelect", 16'(aluSrcBSelect),
                             16'(kind == ctrlPkg::clsAluImm));
                if (kind == ctrlPkg::clsAluReg) begin
                    compareField("regFileOutBSelect", 16'(regFileOutBSelect), 16'(expRegB));
                end
            end
            ctrlPkg::clsIn, ctrlPkg::clsLoad, ctrlPkg::clsStore: begin
                if (kind != ctrlPkg::clsIn) begin
                    compareField("regFileOutBSelect", 16'(regFileOutBSelect), 16'(expRegB));
                end
                if (phase == 1) begin
                    compareField("regFileSrc", 16'(regFileSrc), 16'(ctrlPkg::regSrcIo));
                end
            end
            ctrlPkg::clsJmp, ctrlPkg::clsCall: begin
                if (!taken) begin
                    compareField("iMemAddrSelect", 16'(iMemAddrSelect),
                                 16'(ctrlPkg::pcSrcPlusOne));
                end else if (kind == ctrlPkg::clsJmp && phase == 1) begin
                    compareField("iMemAddrSelect", 16'(iMemAddrSelect),
                                 16'(ctrlPkg::pcSrcInstr));   // target from the word
                end
                if (callPush) begin
                    compareField("regFileOutBSelect", 16'(regFileOutBSelect), 16'(SpLowReg));
                    compareField("dMemDataSelect", 16'(dMemDataSelect), (phase == 0) ?
                                 16'(ctrlPkg::dataPcLow) : 16'(ctrlPkg::dataPcHigh));
                end
            end
            ctrlPkg::clsRet: begin
                if (retPop) begin
                    compareField("dMemIOAddressSelect", 16'(dMemIOAddressSelect),
                                 16'(ctrlPkg::ioAddrPairInc));
                end
            end
            ctrlPkg::clsHlt: begin
                compareField("iMemReadEnable", 16'(iMemReadEnable), 16'(0));
            end
            default: begin
                compareField("regFileIncPair", 16'(regFileIncPair), 16'(0));
            end
        endcase
    endtask

    task automatic runInstruction(input int k);
        logic [15:0] fields;
        logic [2:0]  riMode;
        logic [4:0]  opcode;
        logic [15:0] word;
        logic        c;
        logic        z;
        logic        n;
        logic        done;
        int          variant;
        fields  = 16'($random(seed));
        riMode  = 3'($unsigned($random(seed)) % 7);   // 7 is not an R-I mode
        opcode  = 5'(1 + $unsigned($random(seed)) % 12);
        variant = int'($unsigned($random(seed)) % 3);
        c       = 1'($random(seed));
        z       = 1'($random(seed));
        n       = 1'($random(seed));
        kind    = ctrlPkg::opClassT'(k);
        case (kind)
            ctrlPkg::clsAluImm: word = {fields[15:4], riMode, 1'b1};
            ctrlPkg::clsAluReg: word = {fields[15:8], opcode, ctrlPkg::formatReg};
            ctrlPkg::clsIn:     word = {fields[15:3], ctrlPkg::formatIn};
            ctrlPkg::clsOut:    word = {fields[15:3], ctrlPkg::formatOut};
            ctrlPkg::clsLoad:   word = {fields[15:8], ctrlPkg::opLoad, ctrlPkg::formatReg};
            ctrlPkg::clsStore:  word = {fields[15:8], ctrlPkg::opStore, ctrlPkg::formatReg};
            ctrlPkg::clsJmp:    word = {fields[15:8], ctrlPkg::opJmp, ctrlPkg::formatReg};
            ctrlPkg::clsCall:   word = {fields[15:8], ctrlPkg::opCall, ctrlPkg::formatReg};
            ctrlPkg::clsRet:    word = {fields[15:8], ctrlPkg::opRet, ctrlPkg::formatReg};
            ctrlPkg::clsHlt:    word = {fields[15:8], ctrlPkg::opHlt, ctrlPkg::formatReg};
            default: begin
                // unused format, invalid R-I mode, or opcode zero
                if (variant == 0) word = {fields[15:3], 3'b110};
                else if (variant == 1) word = {fields[15:4], 4'b1111};
                else word = {fields[15:8], 8'h00};
            end
        endcase
        expMode  = (kind == ctrlPkg::clsAluImm) ? {1'b0, riMode} : opcode[3:0];
        expFlags = (kind == ctrlPkg::clsAluReg) || (riMode != 3'd0);  // ldi sets no flags
        expRegB  = (kind == ctrlPkg::clsAluReg) ? fields[11:8] : {fields[11:9], 1'b0};
        taken    = condHolds(fields[15:13], c, z, n);
        case (kind)
            ctrlPkg::clsIn, ctrlPkg::clsLoad:  expLen = 2;
            ctrlPkg::clsJmp, ctrlPkg::clsCall: expLen = taken ? 2 : 1;
            ctrlPkg::clsRet:                   expLen = taken ? 3 : 1;
            ctrlPkg::clsHlt:                   expLen = hltHold;
            default:                           expLen = 1;
        endcase
        @(posedge clk);
        iMemOut      <= word;
        carryFlag    <= c;
        zeroFlag     <= z;
        negativeFlag <= n;
        phase = 0;
        done  = 1'b0;
        while (!done) begin
            @(negedge clk);
            verifyCycle();
            if (kind == ctrlPkg::clsHlt) done = (phase == hltHold - 1);
            else done = (pcWriteEn === 1'b1);   // word is released after completion
            phase++;
            if (!done) @(posedge clk);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rstN         = 1'b0;
        iMemOut      = '0;
        carryFlag    = 1'b0;
        zeroFlag     = 1'b0;
        negativeFlag = 1'b0;
        repeat (resetCycles) begin
            @(negedge clk);
            expectIdle();
        end
        @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        expectIdle();   // first cycle out of reset
        for (int i = 0; i < numInstr; i++) begin
            runInstruction((i < 11) ? i : int'($unsigned($random(seed)) % 11));
        end
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src/cpuControl.sv
module cpuControl #(
    parameter ctrlPkg::regSelT SpLowReg = 4'd14
) (
    input  logic                clk,
    input  logic                rstN,
    input  ctrlPkg::instrT      iMemOut,
    input  logic                carryFlag,
    input  logic                zeroFlag,
    input  logic                negativeFlag,
    output ctrlPkg::regSrcT     regFileSrc,
    output ctrlPkg::regSelT     regFileOutBSelect,
    output logic                regFileWriteEnable,
    output logic                regFileIncPair,
    output logic                regFileDecPair,
    output logic                aluSrcBSelect,
    output ctrlPkg::aluModeT    aluMode,
    output logic                flagEnable,
    output ctrlPkg::dataSelT    dMemDataSelect,
    output ctrlPkg::ioAddrSelT  dMemIOAddressSelect,
    output logic                dMemIOWriteEn,
    output logic                dMemIOReadEn,
    output ctrlPkg::pcSrcT      iMemAddrSelect,
    output logic                iMemReadEnable,
    output logic                pcWriteEn
);

    decodeIf decBus ();  // decoded word, decoder to sequencer

    instrDecoder #(
        .SpLowReg(SpLowReg)
    ) uDecoder (
        .iMemOut     (iMemOut),
        .carryFlag   (carryFlag),
        .zeroFlag    (zeroFlag),
        .negativeFlag(negativeFlag),
        .dec         (decBus.decoder)
    );

    stepSequencer uSequencer (
        .clk                (clk),
        .rstN               (rstN),
        .dec                (decBus.sequencer),
        .regFileSrc         (regFileSrc),
        .regFileOutBSelect  (regFileOutBSelect),
        .regFileWriteEnable (regFileWriteEnable),
        .regFileIncPair     (regFileIncPair),
        .regFileDecPair     (regFileDecPair),
        .aluSrcBSelect      (aluSrcBSelect),
        .aluMode            (aluMode),
        .flagEnable         (flagEnable),
        .dMemDataSelect     (dMemDataSelect),
        .dMemIOAddressSelect(dMemIOAddressSelect),
        .dMemIOWriteEn      (dMemIOWriteEn),
        .dMemIOReadEn       (dMemIOReadEn),
        .iMemAddrSelect     (iMemAddrSelect),
        .iMemReadEnable     (iMemReadEnable),
        .pcWriteEn          (pcWriteEn)
    );

endmodule

// File: src/stepSequencer.sv
module stepSequencer (
    input  logic                clk,
    input  logic                rstN,
    decodeIf.sequencer          dec,
    output ctrlPkg::regSrcT     regFileSrc,
    output ctrlPkg::regSelT     regFileOutBSelect,
    output logic                regFileWriteEnable,
    output logic                regFileIncPair,
    output logic                regFileDecPair,
    output logic                aluSrcBSelect,
    output ctrlPkg::aluModeT    aluMode,
    output logic                flagEnable,
    output ctrlPkg::dataSelT    dMemDataSelect,
    output ctrlPkg::ioAddrSelT  dMemIOAddressSelect,
    output logic                dMemIOWriteEn,
    output logic                dMemIOReadEn,
    output ctrlPkg::pcSrcT      iMemAddrSelect,
    output logic                iMemReadEnable,
    output logic                pcWriteEn
);

    ctrlPkg::stepT step;
    ctrlPkg::stepT nextStep;
    logic          running;  // low in the first cycle after reset

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            step    <= ctrlPkg::stFetch;
            running <= 1'b0;
        end else begin
            step    <= nextStep;
            running <= 1'b1;
        end
    end

    always_comb begin
        nextStep           = ctrlPkg::stFetch;
        regFileWriteEnable = 1'b0;
        regFileIncPair     = 1'b0;
        regFileDecPair     = 1'b0;
        dMemIOWriteEn      = 1'b0;
        dMemIOReadEn       = 1'b0;
        dMemDataSelect     = ctrlPkg::dataAlu;
        iMemAddrSelect     = ctrlPkg::pcSrcCurrent;
        iMemReadEnable     = 1'b1;
        pcWriteEn          = 1'b1;
        case (step)
            ctrlPkg::stFetch: begin
                case (dec.opClass)
                    ctrlPkg::clsAluImm, ctrlPkg::clsAluReg: begin
                        regFileWriteEnable = 1'b1;
                    end
                    ctrlPkg::clsIn, ctrlPkg::clsLoad: begin
                        dMemIOReadEn   = 1'b1;  // data is written back next cycle
                        iMemReadEnable = 1'b0;
                        pcWriteEn      = 1'b0;
                        nextStep       = ctrlPkg::stSecond;
                    end
                    ctrlPkg::clsOut, ctrlPkg::clsStore: begin
                        dMemIOWriteEn = 1'b1;
                    end
                    ctrlPkg::clsJmp: begin
                        if (dec.condMet) begin
                            pcWriteEn = 1'b0;
                            nextStep  = ctrlPkg::stSecond;
                        end else begin
                            iMemAddrSelect = ctrlPkg::pcSrcPlusOne;
                        end
                    end
                    ctrlPkg::clsCall: begin
                        if (dec.condMet) begin
                            regFileDecPair = 1'b1;
                            dMemIOWriteEn  = 1'b1;
                            dMemDataSelect = ctrlPkg::dataPcLow;  // low byte pushed first
                            pcWriteEn      = 1'b0;
                            nextStep       = ctrlPkg::stCallHigh;
                        end else begin
                            iMemAddrSelect = ctrlPkg::pcSrcPlusOne;
                        end
                    end
                    ctrlPkg::clsRet: begin
                        if (dec.condMet) begin
                            dMemIOReadEn   = 1'b1;
                            regFileIncPair = 1'b1;
                            iMemAddrSelect = ctrlPkg::pcSrcReturn;
                            iMemReadEnable = 1'b0;
                            pcWriteEn      = 1'b0;
                            nextStep       = ctrlPkg::stRetWait;
                        end
                    end
                    ctrlPkg::clsHlt: begin
                        iMemReadEnable = 1'b0;  // parked until the word changes
                        pcWriteEn      = 1'b0;
                    end
                    default: begin
                    end
                endcase
            end
            ctrlPkg::stSecond: begin
                if (dec.opClass == ctrlPkg::clsJmp) begin
                    iMemAddrSelect = ctrlPkg::pcSrcInstr;  // target word
                end else if (dec.opClass inside {ctrlPkg::clsIn, ctrlPkg::clsLoad}) begin
                    dMemIOReadEn       = 1'b1;
                    regFileWriteEnable = 1'b1;
                end
            end
            ctrlPkg::stRetWait: begin
                dMemIOReadEn   = 1'b1;
                regFileIncPair = 1'b1;  // second pop
                iMemAddrSelect = ctrlPkg::pcSrcReturn;
                iMemReadEnable = 1'b0;
                pcWriteEn      = 1'b0;
                nextStep       = ctrlPkg::stRetLoad;
            end
            ctrlPkg::stRetLoad: begin
                dMemIOReadEn   = 1'b1;
                iMemAddrSelect = ctrlPkg::pcSrcReturn;
            end
            ctrlPkg::stCallHigh: begin
                regFileDecPair = 1'b1;
                dMemIOWriteEn  = 1'b1;
                dMemDataSelect = ctrlPkg::dataPcHigh;
                iMemAddrSelect = ctrlPkg::pcSrcInstr;
            end
            default: begin
            end
        endcase
        // hold everything off until the first cycle out of reset is over
        if (!running) begin
            nextStep           = ctrlPkg::stFetch;
            regFileWriteEnable = 1'b0;
            regFileIncPair     = 1'b0;
            regFileDecPair     = 1'b0;
            dMemIOWriteEn      = 1'b0;
            dMemIOReadEn       = 1'b0;
            iMemReadEnable     = 1'b0;
            pcWriteEn          = 1'b0;
        end
    end

    assign regFileSrc = (dec.opClass inside {ctrlPkg::clsIn, ctrlPkg::clsLoad}) ?
                        ctrlPkg::regSrcIo : ctrlPkg::regSrcAlu;

    assign regFileOutBSelect   = dec.regBSelect;
    assign aluSrcBSelect       = dec.aluSrcImm;   // 1 selects the 8-bit immediate
    assign aluMode             = dec.aluMode;
    assign flagEnable          = dec.flagEnable;
    assign dMemIOAddressSelect = dec.ioAddrSelect;

endmodule

// File: src/instrDecoder.sv
module instrDecoder #(
    parameter ctrlPkg::regSelT SpLowReg = 4'd14
) (
    input  ctrlPkg::instrT iMemOut,
    input  logic           carryFlag,
    input  logic           zeroFlag,
    input  logic           negativeFlag,
    decodeIf.decoder       dec
);

    ctrlPkg::condT      cond;
    ctrlPkg::opcodeT    opcode;
    ctrlPkg::formatT    format;
    ctrlPkg::riModeT    riMode;
    ctrlPkg::regSelT    pairBase;
    ctrlPkg::opClassT   opClass;
    logic               condMet;
    ctrlPkg::regSelT    regBSelect;
    ctrlPkg::aluModeT   aluMode;
    logic               aluSrcImm;
    logic               flagEnable;
    ctrlPkg::ioAddrSelT ioAddrSelect;

    assign cond     = iMemOut[ctrlPkg::condLsb +: $bits(ctrlPkg::condT)];
    assign opcode   = iMemOut[ctrlPkg::opcodeLsb +: $bits(ctrlPkg::opcodeT)];
    assign format   = iMemOut[ctrlPkg::formatLsb +: $bits(ctrlPkg::formatT)];
    assign riMode   = iMemOut[ctrlPkg::riModeLsb +: $bits(ctrlPkg::riModeT)];
    assign pairBase = {iMemOut[ctrlPkg::pairLsb +: 3], 1'b0};  // even register of the pair

    always_comb begin
        if (iMemOut[ctrlPkg::immBit] && riMode != ctrlPkg::riModeInvalid) begin
            opClass = ctrlPkg::clsAluImm;
        end else if (format == ctrlPkg::formatIn) begin
            opClass = ctrlPkg::clsIn;
        end else if (format == ctrlPkg::formatOut) begin
            opClass = ctrlPkg::clsOut;
        end else if (format == ctrlPkg::formatReg) begin
            if (opcode >= ctrlPkg::opAluRegFirst && opcode <= ctrlPkg::opAluRegLast) begin
                opClass = ctrlPkg::clsAluReg;  // R-R and single-register ops
            end else begin
                case (opcode)
                    ctrlPkg::opLoad:  opClass = ctrlPkg::clsLoad;
                    ctrlPkg::opStore: opClass = ctrlPkg::clsStore;
                    ctrlPkg::opJmp:   opClass = ctrlPkg::clsJmp;
                    ctrlPkg::opCall:  opClass = ctrlPkg::clsCall;
                    ctrlPkg::opRet:   opClass = ctrlPkg::clsRet;
                    ctrlPkg::opHlt:   opClass = ctrlPkg::clsHlt;
                    default:          opClass = ctrlPkg::clsNop;
                endcase
            end
        end else begin
            opClass = ctrlPkg::clsNop;  // anything else is a no-op
        end
    end

    always_comb begin
        case (cond)
            ctrlPkg::condCarry:   condMet = carryFlag;
            ctrlPkg::condNoCarry: condMet = ~carryFlag;
            ctrlPkg::condZero:    condMet = zeroFlag;
            ctrlPkg::condNoZero:  condMet = ~zeroFlag;
            ctrlPkg::condNeg:     condMet = negativeFlag;
            ctrlPkg::condNoNeg:   condMet = ~negativeFlag;
            default:              condMet = 1'b1;  // codes 0 and 7
        endcase
    end

    always_comb begin
        regBSelect   = iMemOut[ctrlPkg::regALsb +: $bits(ctrlPkg::regSelT)];
        aluMode      = ctrlPkg::aluPassB;
        aluSrcImm    = 1'b0;
        flagEnable   = 1'b0;
        ioAddrSelect = ctrlPkg::ioAddrPair;
        case (opClass)
            ctrlPkg::clsAluImm: begin
                aluMode    = {1'b0, riMode};
                aluSrcImm  = 1'b1;
                flagEnable = (riMode != ctrlPkg::riModeLdi);
            end
            ctrlPkg::clsAluReg: begin
                regBSelect = iMemOut[ctrlPkg::regBLsb +: $bits(ctrlPkg::regSelT)];
                aluMode    = iMemOut[ctrlPkg::aluModeLsb +: $bits(ctrlPkg::aluModeT)];
                flagEnable = 1'b1;
            end
            ctrlPkg::clsIn, ctrlPkg::clsOut: begin
                ioAddrSelect = ctrlPkg::ioAddrImm;
            end
            ctrlPkg::clsLoad, ctrlPkg::clsStore: begin
                regBSelect = pairBase;
                aluMode    = ctrlPkg::aluPassA;  // store data comes from reg A
            end
            ctrlPkg::clsCall: begin
                regBSelect = SpLowReg;
            end
            ctrlPkg::clsRet: begin
                regBSelect   = SpLowReg;
                ioAddrSelect = ctrlPkg::ioAddrPairInc;
            end
            default: begin
            end
        endcase
    end

    assign dec.opClass      = opClass;
    assign dec.condMet      = condMet;
    assign dec.regBSelect   = regBSelect;
    assign dec.aluMode      = aluMode;
    assign dec.aluSrcImm    = aluSrcImm;
    assign dec.flagEnable   = flagEnable;
    assign dec.ioAddrSelect = ioAddrSelect;

endmodule

// File: src/decodeIf.sv
interface decodeIf;

    ctrlPkg::opClassT  opClass;
    logic              condMet;       // condition true for the current flags
    ctrlPkg::regSelT   regBSelect;
    ctrlPkg::aluModeT  aluMode;
    logic              aluSrcImm;
    logic              flagEnable;
    ctrlPkg::ioAddrSelT ioAddrSelect;

    modport decoder (
        output opClass,
        output condMet,
        output regBSelect,
        output aluMode,
        output aluSrcImm,
        output flagEnable,
        output ioAddrSelect
    );

    modport sequencer (
        input opClass,
        input condMet,
        input regBSelect,
        input aluMode,
        input aluSrcImm,
        input flagEnable,
        input ioAddrSelect
    );

endinterface

// File: src/ctrlPkg.sv
package ctrlPkg;

    typedef logic [15:0] instrT;
    typedef logic [3:0]  regSelT;
    typedef logic [3:0]  aluModeT;
    typedef logic [2:0]  condT;
    typedef logic [4:0]  opcodeT;
    typedef logic [2:0]  formatT;
    typedef logic [2:0]  riModeT;
    typedef logic [1:0]  regSrcT;
    typedef logic [1:0]  dataSelT;
    typedef logic [1:0]  ioAddrSelT;
    typedef logic [2:0]  pcSrcT;

    // field positions inside the instruction word
    localparam int condLsb    = 13;   // cond in 15..13
    localparam int regALsb    = 12;   // destination / A register
    localparam int regBLsb    = 8;    // source register of R-R
    localparam int pairLsb    = 9;    // pair index, base is 2*ppp
    localparam int opcodeLsb  = 3;
    localparam int aluModeLsb = 3;    // R-R mode sits in 6..3
    localparam int riModeLsb  = 1;
    localparam int formatLsb  = 0;
    localparam int immBit     = 0;    // set for R-I words

    localparam formatT formatReg = 3'b000;
    localparam formatT formatIn  = 3'b010;
    localparam formatT formatOut = 3'b100;

    localparam riModeT riModeLdi     = 3'd0;   // load immediate, no flags
    localparam riModeT riModeInvalid = 3'd7;

    localparam opcodeT opAluRegFirst = 5'b00001;
    localparam opcodeT opAluRegLast  = 5'b01100;
    localparam opcodeT opStore       = 5'b01101;
    localparam opcodeT opLoad        = 5'b10000;
    localparam opcodeT opJmp         = 5'b10110;
    localparam opcodeT opCall        = 5'b10111;
    localparam opcodeT opRet         = 5'b11000;
    localparam opcodeT opHlt         = 5'b11101;

    // condition codes, 0 and 7 are unconditional
    localparam condT condCarry   = 3'd1;
    localparam condT condNoCarry = 3'd2;
    localparam condT condZero    = 3'd3;
    localparam condT condNoZero  = 3'd4;
    localparam condT condNeg     = 3'd5;
    localparam condT condNoNeg   = 3'd6;

    localparam aluModeT aluPassB = 4'b0000;
    localparam aluModeT aluAnd   = 4'b0001;
    localparam aluModeT aluOr    = 4'b0010;
    localparam aluModeT aluPassA = 4'b1101;

    localparam regSrcT regSrcAlu = 2'b00;
    localparam regSrcT regSrcIo  = 2'b10;   // data memory / IO read data

    localparam dataSelT dataPcHigh = 2'b00;
    localparam dataSelT dataPcLow  = 2'b01;
    localparam dataSelT dataAlu    = 2'b10;

    localparam ioAddrSelT ioAddrPair    = 2'b00;
    localparam ioAddrSelT ioAddrImm     = 2'b01;   // zero-extended 8-bit field
    localparam ioAddrSelT ioAddrPairInc = 2'b10;   // SP + 1 on pops

    localparam pcSrcT pcSrcPlusOne = 3'b000;   // skips the address word
    localparam pcSrcT pcSrcCurrent = 3'b001;
    localparam pcSrcT pcSrcInstr   = 3'b011;
    localparam pcSrcT pcSrcPair    = 3'b100;
    localparam pcSrcT pcSrcReturn  = 3'b101;   // return reg with popped byte

    typedef enum logic [3:0] {
        clsAluImm, clsAluReg, clsIn, clsOut, clsLoad, clsStore,
        clsJmp, clsCall, clsRet, clsHlt, clsNop
    } opClassT;

    typedef enum logic [2:0] {
        stFetch, stSecond, stRetWait, stRetLoad, stCallHigh
    } stepT;

endpackage
